//--- design/masku_pkg.sv
package masku_pkg;

  ////////////////////////////////////////
  // Datapath sizes
  ////////////////////////////////////////

  // Lanes and the width of one lane word
  localparam int unsigned NrLanes  = 2;
  localparam int unsigned ElenBits = 64;

  // One register word spans every lane, bits in flat lane order
  localparam int unsigned WordBits  = NrLanes * ElenBits;
  localparam int unsigned WordShift = $clog2(WordBits);

  // Instruction ids known to the sequencer
  localparam int unsigned NrVInsn = 8;

  // Entries per lane in the result queue
  localparam int unsigned ResultQueueDepth = 2;

  ////////////////////////////////////////
  // Register file addressing
  ////////////////////////////////////////

  // Words per vector register, so address = vd * 8 + word index
  localparam int unsigned VrfWordsPerReg = 8;
  localparam int unsigned VrfWordIdxBits = $clog2(VrfWordsPerReg);
  localparam int unsigned VregBits       = 5;
  localparam int unsigned VaddrBits      = VregBits + VrfWordIdxBits;
  localparam int unsigned VlenBits       = 16;

  typedef logic [ElenBits-1:0]        elen_t;
  typedef logic [VlenBits-1:0]        vlen_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [VregBits-1:0]        vreg_t;
  typedef logic [VaddrBits-1:0]       vaddr_t;

  // One lane's entry in the result queue
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
  } result_payload_t;

endpackage

//--- design/masku_insn_ctrl.sv
module masku_insn_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Sequencer request
  input  logic                            pe_req_valid_i,
  output logic                            pe_req_ready_o,
  input  masku_pkg::vid_t                 pe_req_id_i,
  input  masku_pkg::vlen_t                pe_req_vl_i,
  input  logic                            pe_req_vm_i,
  input  masku_pkg::vreg_t                pe_req_vd_i,
  // Progress from the execute and commit stages
  input  logic                            word_issued_i,
  input  logic                            word_popped_i,
  // Held instruction
  output logic                            insn_valid_o,
  output logic                            insn_vm_o,
  output masku_pkg::vreg_t                insn_vd_o,
  output masku_pkg::vlen_t                insn_vl_o,
  output masku_pkg::vid_t                 insn_id_o,
  output masku_pkg::vlen_t                issue_remaining_o,
  // Done response, one bit per id
  output logic [masku_pkg::NrVInsn-1:0]   vinsn_done_o
);

  // Instruction queue of depth one
  logic             insn_valid_q;
  logic             vm_q;
  masku_pkg::vreg_t vd_q;
  masku_pkg::vlen_t vl_q;
  masku_pkg::vid_t  id_q;

  // Bits still to issue and still to commit
  masku_pkg::vlen_t issue_cnt_q;
  masku_pkg::vlen_t commit_cnt_q;

  logic [masku_pkg::NrVInsn-1:0] done_q;

  logic accept;
  logic last_pop;

  // Only one instruction in flight
  assign pe_req_ready_o = !insn_valid_q;
  assign accept         = pe_req_valid_i && pe_req_ready_o;

  // Commit counter runs out with this pop
  assign last_pop = insn_valid_q && word_popped_i &&
                    (commit_cnt_q <= masku_pkg::vlen_t'(masku_pkg::WordBits));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_valid_q <= 1'b0;
      vm_q         <= 1'b0;
      vd_q         <= '0;
      vl_q         <= '0;
      id_q         <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_q       <= '0;
    end else begin
      // Done is a single-cycle pulse
      done_q <= '0;
      if (accept) begin
        insn_valid_q <= 1'b1;
        vm_q         <= pe_req_vm_i;
        vd_q         <= pe_req_vd_i;
        vl_q         <= pe_req_vl_i;
        id_q         <= pe_req_id_i;
        issue_cnt_q  <= pe_req_vl_i;
        commit_cnt_q <= pe_req_vl_i;
      end
      // Saturating decrement per issued word
      if (word_issued_i) begin
        if (issue_cnt_q > masku_pkg::vlen_t'(masku_pkg::WordBits)) begin
          issue_cnt_q <= issue_cnt_q - masku_pkg::vlen_t'(masku_pkg::WordBits);
        end else begin
          issue_cnt_q <= '0;
        end
      end
      // Saturating decrement per popped word
      if (word_popped_i) begin
        if (commit_cnt_q > masku_pkg::vlen_t'(masku_pkg::WordBits)) begin
          commit_cnt_q <= commit_cnt_q - masku_pkg::vlen_t'(masku_pkg::WordBits);
        end else begin
          commit_cnt_q <= '0;
        end
      end
      // Last word written, free the slot
      if (last_pop) begin
        insn_valid_q <= 1'b0;
        done_q[id_q] <= 1'b1;
      end
    end
  end

  assign insn_valid_o      = insn_valid_q;
  assign insn_vm_o         = vm_q;
  assign insn_vd_o         = vd_q;
  assign insn_vl_o         = vl_q;
  assign insn_id_o         = id_q;
  assign issue_remaining_o = issue_cnt_q;
  assign vinsn_done_o      = done_q;

  // Execute stage never issues past the vector length
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_issued_i |-> (issue_cnt_q != '0));

  // A new request only enters once the previous one has fully drained
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> ((issue_cnt_q == '0) && (commit_cnt_q == '0)));

endmodule

//--- design/masku_bit_merge.sv
module masku_bit_merge (
  // Held instruction
  input  logic                                                 insn_valid_i,
  input  logic                                                 insn_vm_i,
  input  masku_pkg::vreg_t                                     insn_vd_i,
  input  masku_pkg::vlen_t                                     insn_vl_i,
  input  masku_pkg::vid_t                                      insn_id_i,
  input  masku_pkg::vlen_t                                     issue_remaining_i,
  input  logic                                                 queue_full_i,
  // Operands from the lanes
  input  masku_pkg::elen_t [masku_pkg::NrLanes-1:0]            operand_a_i,
  input  logic [masku_pkg::NrLanes-1:0]                        operand_a_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                        operand_a_ready_o,
  input  masku_pkg::elen_t [masku_pkg::NrLanes-1:0]            operand_b_i,
  input  logic [masku_pkg::NrLanes-1:0]                        operand_b_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                        operand_b_ready_o,
  input  masku_pkg::elen_t [masku_pkg::NrLanes-1:0]            operand_m_i,
  input  logic [masku_pkg::NrLanes-1:0]                        operand_m_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                        operand_m_ready_o,
  // Toward the instruction and commit stages
  output logic                                                 word_issued_o,
  output logic                                                 push_o,
  output masku_pkg::result_payload_t [masku_pkg::NrLanes-1:0]  payload_o
);

  // Flat views, lane 0 in the low bits
  logic [masku_pkg::WordBits-1:0] a_flat;
  logic [masku_pkg::WordBits-1:0] b_flat;
  logic [masku_pkg::WordBits-1:0] m_flat;
  logic [masku_pkg::WordBits-1:0] bit_enable;
  logic [masku_pkg::WordBits-1:0] merged;

  masku_pkg::vlen_t   consumed;
  masku_pkg::vlen_t   word_idx;
  masku_pkg::vaddr_t  word_addr;
  logic               operands_valid;
  logic               consume;

  assign a_flat = operand_a_i;
  assign b_flat = operand_b_i;
  assign m_flat = operand_m_i;

  ////////////////////////////////////////
  // Consume rule
  ////////////////////////////////////////

  // Mask word only needed for masked instructions
  assign operands_valid = (&operand_a_valid_i) && (&operand_b_valid_i) &&
                          (insn_vm_i || (&operand_m_valid_i));
  assign consume = insn_valid_i && (issue_remaining_i != '0) &&
                   !queue_full_i && operands_valid;

  // All lanes acknowledged in the same cycle
  assign operand_a_ready_o = {masku_pkg::NrLanes{consume}};
  assign operand_b_ready_o = {masku_pkg::NrLanes{consume}};
  assign operand_m_ready_o = {masku_pkg::NrLanes{consume && !insn_vm_i}};

  assign word_issued_o = consume;
  assign push_o        = consume;

  ////////////////////////////////////////
  // Bit merge
  ////////////////////////////////////////

  always_comb begin
    // Tail bits beyond the remaining length keep the old value
    for (int b = 0; b < masku_pkg::WordBits; b++) begin
      bit_enable[b] = masku_pkg::vlen_t'(b) < issue_remaining_i;
    end
    // Predication by the mask register
    if (!insn_vm_i) begin
      bit_enable = bit_enable & m_flat;
    end
  end

  assign merged = (a_flat & bit_enable) | (b_flat & ~bit_enable);

  // Word index inside the destination register
  assign consumed  = insn_vl_i - issue_remaining_i;
  assign word_idx  = consumed >> masku_pkg::WordShift;
  assign word_addr = {insn_vd_i, word_idx[masku_pkg::VrfWordIdxBits-1:0]};

  always_comb begin
    for (int l = 0; l < masku_pkg::NrLanes; l++) begin
      payload_o[l].id    = insn_id_i;
      payload_o[l].addr  = word_addr;
      payload_o[l].wdata = merged[l*masku_pkg::ElenBits +: masku_pkg::ElenBits];
    end
  end

  // A pushed word stays inside its destination register
  always_comb begin
    if (push_o) begin
      assert (word_idx < masku_pkg::VrfWordsPerReg)
        else $error("masku_bit_merge: word index out of range");
    end
  end

endmodule

//--- design/masku_result_queue.sv
module masku_result_queue (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  // Push side from the execute stage
  input  logic                                                 push_i,
  input  masku_pkg::result_payload_t [masku_pkg::NrLanes-1:0]  payload_i,
  output logic                                                 queue_full_o,
  output logic                                                 word_popped_o,
  // Write requests toward the lanes
  output logic [masku_pkg::NrLanes-1:0]                        result_req_o,
  output masku_pkg::vid_t [masku_pkg::NrLanes-1:0]             result_id_o,
  output masku_pkg::vaddr_t [masku_pkg::NrLanes-1:0]           result_addr_o,
  output masku_pkg::elen_t [masku_pkg::NrLanes-1:0]            result_wdata_o,
  input  logic [masku_pkg::NrLanes-1:0]                        result_gnt_i
);

  localparam int unsigned PtrBits = $clog2(masku_pkg::ResultQueueDepth);

  typedef logic [PtrBits-1:0] ptr_t;
  typedef logic [PtrBits:0]   cnt_t;

  // Storage, one slot per lane in every entry
  masku_pkg::result_payload_t [masku_pkg::NrLanes-1:0] queue_q [masku_pkg::ResultQueueDepth];
  logic [masku_pkg::NrLanes-1:0] valid_q [masku_pkg::ResultQueueDepth];

  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t cnt_q;

  logic [masku_pkg::NrLanes-1:0] head_pending;
  logic                          pop;

  assign queue_full_o = (cnt_q == cnt_t'(masku_pkg::ResultQueueDepth));

  // Head lanes still waiting after this cycle's grants
  assign head_pending  = valid_q[rd_ptr_q] & ~result_gnt_i;
  assign pop           = (cnt_q != '0) && (head_pending == '0);
  assign word_popped_o = pop;

  // Head entry drives every lane
  always_comb begin
    for (int l = 0; l < masku_pkg::NrLanes; l++) begin
      result_req_o[l]   = valid_q[rd_ptr_q][l];
      result_id_o[l]    = queue_q[rd_ptr_q][l].id;
      result_addr_o[l]  = queue_q[rd_ptr_q][l].addr;
      result_wdata_o[l] = queue_q[rd_ptr_q][l].wdata;
    end
  end

  ////////////////////////////////////////
  // Pointers and valid bits
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int e = 0; e < masku_pkg::ResultQueueDepth; e++) begin
        valid_q[e] <= '0;
      end
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // A granted lane drops its request
      valid_q[rd_ptr_q] <= head_pending;
      // New word requests on every lane
      if (push_i) begin
        valid_q[wr_ptr_q] <= '1;
        wr_ptr_q          <= wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
      cnt_q <= cnt_q + cnt_t'(push_i) - cnt_t'(pop);
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      queue_q[wr_ptr_q] <= payload_i;
    end
  end

  // Execute stage respects back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !queue_full_o);

  // Lanes only grant an outstanding request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_gnt_i & ~result_req_o) == '0);

endmodule

//--- design/masku.sv
module masku (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Sequencer
  input  logic                                         pe_req_valid_i,
  output logic                                         pe_req_ready_o,
  input  masku_pkg::vid_t                              pe_req_id_i,
  input  masku_pkg::vlen_t                             pe_req_vl_i,
  input  logic                                         pe_req_vm_i,
  input  masku_pkg::vreg_t                             pe_req_vd_i,
  output logic [masku_pkg::NrVInsn-1:0]                vinsn_done_o,
  // Operands from the lanes
  input  masku_pkg::elen_t [masku_pkg::NrLanes-1:0]    operand_a_i,
  input  logic [masku_pkg::NrLanes-1:0]                operand_a_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                operand_a_ready_o,
  input  masku_pkg::elen_t [masku_pkg::NrLanes-1:0]    operand_b_i,
  input  logic [masku_pkg::NrLanes-1:0]                operand_b_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                operand_b_ready_o,
  input  masku_pkg::elen_t [masku_pkg::NrLanes-1:0]    operand_m_i,
  input  logic [masku_pkg::NrLanes-1:0]                operand_m_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                operand_m_ready_o,
  // Results toward the lanes
  output logic [masku_pkg::NrLanes-1:0]                result_req_o,
  output masku_pkg::vid_t [masku_pkg::NrLanes-1:0]     result_id_o,
  output masku_pkg::vaddr_t [masku_pkg::NrLanes-1:0]   result_addr_o,
  output masku_pkg::elen_t [masku_pkg::NrLanes-1:0]    result_wdata_o,
  input  logic [masku_pkg::NrLanes-1:0]                result_gnt_i
);

  // Held instruction
  logic             insn_valid;
  logic             insn_vm;
  masku_pkg::vreg_t insn_vd;
  masku_pkg::vlen_t insn_vl;
  masku_pkg::vid_t  insn_id;
  masku_pkg::vlen_t issue_remaining;

  // Stage handshakes
  logic word_issued;
  logic word_popped;
  logic push;
  logic queue_full;
  masku_pkg::result_payload_t [masku_pkg::NrLanes-1:0] payload;

  // Instruction queue and counters
  masku_insn_ctrl insn_ctrl_inst (
    .clk_i, .rst_ni,
    .pe_req_valid_i, .pe_req_ready_o,
    .pe_req_id_i, .pe_req_vl_i, .pe_req_vm_i, .pe_req_vd_i,
    .word_issued_i     (word_issued),
    .word_popped_i     (word_popped),
    .insn_valid_o      (insn_valid),
    .insn_vm_o         (insn_vm),
    .insn_vd_o         (insn_vd),
    .insn_vl_o         (insn_vl),
    .insn_id_o         (insn_id),
    .issue_remaining_o (issue_remaining),
    .vinsn_done_o
  );

  // Operand merge, combinational
  masku_bit_merge bit_merge_inst (
    .insn_valid_i      (insn_valid),
    .insn_vm_i         (insn_vm),
    .insn_vd_i         (insn_vd),
    .insn_vl_i         (insn_vl),
    .insn_id_i         (insn_id),
    .issue_remaining_i (issue_remaining),
    .queue_full_i      (queue_full),
    .operand_a_i, .operand_a_valid_i, .operand_a_ready_o,
    .operand_b_i, .operand_b_valid_i, .operand_b_ready_o,
    .operand_m_i, .operand_m_valid_i, .operand_m_ready_o,
    .word_issued_o     (word_issued),
    .push_o            (push),
    .payload_o         (payload)
  );

  // Per-lane result queue
  masku_result_queue result_queue_inst (
    .clk_i, .rst_ni,
    .push_i        (push),
    .payload_i     (payload),
    .queue_full_o  (queue_full),
    .word_popped_o (word_popped),
    .result_req_o, .result_id_o, .result_addr_o, .result_wdata_o,
    .result_gnt_i
  );

endmodule

//--- test/tb_clock.sv
module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  // Period of 20
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // Reset held low for 5 rising edges
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- test/tb_masku.sv
module tb_masku;

  logic clk_i;
  logic rst_ni;

  // Sequencer side
  logic                                      pe_req_valid_i;
  logic                                      pe_req_ready_o;
  masku_pkg::vid_t                           pe_req_id_i;
  masku_pkg::vlen_t                          pe_req_vl_i;
  logic                                      pe_req_vm_i;
  masku_pkg::vreg_t                          pe_req_vd_i;
  logic [masku_pkg::NrVInsn-1:0]             vinsn_done_o;
  // Lane side
  masku_pkg::elen_t [masku_pkg::NrLanes-1:0] operand_a_i;
  masku_pkg::elen_t [masku_pkg::NrLanes-1:0] operand_b_i;
  masku_pkg::elen_t [masku_pkg::NrLanes-1:0] operand_m_i;
  logic [masku_pkg::NrLanes-1:0]             operand_a_valid_i;
  logic [masku_pkg::NrLanes-1:0]             operand_b_valid_i;
  logic [masku_pkg::NrLanes-1:0]             operand_m_valid_i;
  logic [masku_pkg::NrLanes-1:0]             operand_a_ready_o;
  logic [masku_pkg::NrLanes-1:0]             operand_b_ready_o;
  logic [masku_pkg::NrLanes-1:0]             operand_m_ready_o;
  logic [masku_pkg::NrLanes-1:0]             result_req_o;
  masku_pkg::vid_t [masku_pkg::NrLanes-1:0]  result_id_o;
  masku_pkg::vaddr_t [masku_pkg::NrLanes-1:0] result_addr_o;
  masku_pkg::elen_t [masku_pkg::NrLanes-1:0] result_wdata_o;
  logic [masku_pkg::NrLanes-1:0]             result_gnt_i;

  integer                        seed;
  int unsigned                   cycle_cnt = 0;
  // Lanes allowed to grant, and the grant for the next cycle
  logic [masku_pkg::NrLanes-1:0] gnt_enable;
  logic [masku_pkg::NrLanes-1:0] gnt_next;

  // Words written per lane and the words the reference model predicts
  masku_pkg::result_payload_t got_q [masku_pkg::NrLanes][$];
  masku_pkg::result_payload_t exp_q [masku_pkg::NrLanes][$];

  tb_clock clock_inst (.clk_o(clk_i), .rst_no(rst_ni));

  masku masku_inst (.*);

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_payload(input masku_pkg::result_payload_t got,
                               input masku_pkg::result_payload_t exp, input string what);
    if (got.id !== exp.id)
      report_mismatch($sformatf("%s id %0d, expected %0d", what, got.id, exp.id));
    if (got.addr !== exp.addr)
      report_mismatch($sformatf("%s addr %0d, expected %0d", what, got.addr, exp.addr));
    if (got.wdata !== exp.wdata)
      report_mismatch($sformatf("%s wdata %h, expected %h", what, got.wdata, exp.wdata));
  endtask

  task automatic check_done(input logic [masku_pkg::NrVInsn-1:0] got,
                            input logic [masku_pkg::NrVInsn-1:0] exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s done %b, expected %b", what, got, exp));
  endtask

  // Per-lane readies and requests
  task automatic check_lanes(input logic [masku_pkg::NrLanes-1:0] got,
                             input logic [masku_pkg::NrLanes-1:0] exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Bit takes a below the remaining length when unmasked or its mask bit is set
  function automatic logic [masku_pkg::WordBits-1:0] merge_word(
      input logic [masku_pkg::WordBits-1:0] a, input logic [masku_pkg::WordBits-1:0] b,
      input logic [masku_pkg::WordBits-1:0] m, input logic vm,
      input masku_pkg::vlen_t remaining);
    logic [masku_pkg::WordBits-1:0] w;
    for (int i = 0; i < masku_pkg::WordBits; i++) begin
      w[i] = ((i < int'(remaining)) && (vm || m[i])) ? a[i] : b[i];
    end
    return w;
  endfunction

  function automatic logic [masku_pkg::WordBits-1:0] rand_word();
    logic [masku_pkg::WordBits-1:0] w;
    for (int k = 0; k < masku_pkg::WordBits / 32; k++) begin
      w[k*32 +: 32] = $random(seed);
    end
    return w;
  endfunction

  ////////////////////////////////////////
  // Lane write port model
  ////////////////////////////////////////

  // Grant a pending request for one cycle, record the word on its grant
  initial begin
    masku_pkg::result_payload_t rec;
    result_gnt_i <= '0;
    forever begin
      @(negedge clk_i);
      for (int l = 0; l < masku_pkg::NrLanes; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          rec.id    = result_id_o[l];
          rec.addr  = result_addr_o[l];
          rec.wdata = result_wdata_o[l];
          got_q[l].push_back(rec);
        end
        gnt_next[l] = gnt_enable[l] && result_req_o[l] && !result_gnt_i[l];
      end
      @(posedge clk_i);
      result_gnt_i <= gnt_next;
    end
  end

  // Watchdog for a stuck handshake
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > 4000) begin
      $display("ERRORS FOUND");
      $fatal(1, "Timeout: the run went past 4000 cycles without finishing");
    end
  end

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  task automatic send_request(input masku_pkg::vid_t id, input masku_pkg::vlen_t vl,
                              input logic vm, input masku_pkg::vreg_t vd);
    @(posedge clk_i);
    pe_req_valid_i <= 1'b1;
    pe_req_id_i    <= id;
    pe_req_vl_i    <= vl;
    pe_req_vm_i    <= vm;
    pe_req_vd_i    <= vd;
    @(negedge clk_i);
    while (!pe_req_ready_o) @(negedge clk_i);
    // Accepted on this edge
    @(posedge clk_i);
    pe_req_valid_i <= 1'b0;
    @(negedge clk_i);
    check_flag(pe_req_ready_o, 1'b0, "sequencer ready after acceptance");
  endtask

  // One random word per step, expected payloads queued before the handshake
  task automatic feed_operands(input masku_pkg::vid_t id, input masku_pkg::vlen_t vl,
                               input logic vm, input masku_pkg::vreg_t vd);
    logic [masku_pkg::WordBits-1:0] a;
    logic [masku_pkg::WordBits-1:0] b;
    logic [masku_pkg::WordBits-1:0] m;
    logic [masku_pkg::WordBits-1:0] w;
    masku_pkg::result_payload_t     exp;
    masku_pkg::vlen_t               remaining;
    int                             nwords;
    nwords = (int'(vl) + int'(masku_pkg::WordBits) - 1) / int'(masku_pkg::WordBits);
    for (int n = 0; n < nwords; n++) begin
      a         = rand_word();
      b         = rand_word();
      m         = rand_word();
      remaining = vl - masku_pkg::vlen_t'(n * masku_pkg::WordBits);
      w         = merge_word(a, b, m, vm, remaining);
      for (int l = 0; l < masku_pkg::NrLanes; l++) begin
        exp.id    = id;
        exp.addr  = masku_pkg::vaddr_t'(32'(vd) * masku_pkg::VrfWordsPerReg + n);
        exp.wdata = w[l*masku_pkg::ElenBits +: masku_pkg::ElenBits];
        exp_q[l].push_back(exp);
      end
      @(posedge clk_i);
      operand_a_i       <= a;
      operand_b_i       <= b;
      operand_m_i       <= m;
      operand_a_valid_i <= '1;
      operand_b_valid_i <= '1;
      operand_m_valid_i <= vm ? '0 : '1;
      @(negedge clk_i);
      while (!operand_a_ready_o[0]) @(negedge clk_i);
      check_lanes(operand_a_ready_o, '1, "a ready on consume");
      check_lanes(operand_b_ready_o, '1, "b ready on consume");
      check_lanes(operand_m_ready_o, vm ? '0 : '1, "m ready on consume");
    end
    @(posedge clk_i);
    operand_a_valid_i <= '0;
    operand_b_valid_i <= '0;
    operand_m_valid_i <= '0;
  endtask

  // Done pulse, then every lane's words against the model
  task automatic wait_done_and_check(input masku_pkg::vid_t id, input int nwords,
                                     input string what);
    logic [masku_pkg::NrVInsn-1:0] exp_done;
    exp_done     = '0;
    exp_done[id] = 1'b1;
    @(negedge clk_i);
    while (vinsn_done_o == '0) begin
      check_flag(pe_req_ready_o, 1'b0, {what, ": sequencer ready before done"});
      @(negedge clk_i);
    end
    check_done(vinsn_done_o, exp_done, what);
    check_flag(pe_req_ready_o, 1'b1, {what, ": sequencer ready with done"});
    for (int l = 0; l < masku_pkg::NrLanes; l++) begin
      if (got_q[l].size() != nwords)
        report_mismatch($sformatf("%s lane %0d wrote %0d words, expected %0d",
                                  what, l, got_q[l].size(), nwords));
      for (int n = 0; n < nwords; n++) begin
        check_payload(got_q[l][n], exp_q[l][n], $sformatf("%s lane %0d word %0d", what, l, n));
      end
      got_q[l].delete();
      exp_q[l].delete();
    end
    @(negedge clk_i);
    check_done(vinsn_done_o, '0, {what, ": done after its pulse"});
  endtask

  task automatic run_insn(input masku_pkg::vid_t id, input masku_pkg::vlen_t vl,
                          input logic vm, input masku_pkg::vreg_t vd, input string what);
    send_request(id, vl, vm, vd);
    feed_operands(id, vl, vm, vd);
    wait_done_and_check(id, (int'(vl) + 127) / 128, what);
  endtask

  // Lane 1 granted well before lane 0 while the queue is full
  task automatic hold_then_release_grants();
    logic [masku_pkg::NrLanes-1:0] lane0_only;
    int                            words_taken;
    lane0_only    = '0;
    lane0_only[0] = 1'b1;
    words_taken   = 0;
    @(negedge clk_i);
    // Words consumed before the queue stalls the operands
    while (!(result_req_o == '1 && operand_a_valid_i == '1 && operand_a_ready_o == '0)) begin
      if (operand_a_ready_o[0]) begin
        words_taken++;
      end
      @(negedge clk_i);
    end
    if (words_taken != 2)
      report_mismatch($sformatf("queue took %0d words before stalling, expected 2",
                                words_taken));
    repeat (6) begin
      check_lanes(operand_a_ready_o, '0, "a ready with full queue");
      check_lanes(operand_b_ready_o, '0, "b ready with full queue");
      check_lanes(result_req_o, '1, "requests with full queue");
      check_flag(pe_req_ready_o, 1'b0, "sequencer ready with full queue");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    gnt_enable[1] = 1'b1;
    repeat (5) begin
      @(negedge clk_i);
      check_lanes(operand_a_ready_o, '0, "a ready before lane 0 grant");
    end
    check_lanes(result_req_o, lane0_only, "requests after lane 1 grant");
    if (got_q[1].size() != 1 || got_q[0].size() != 0)
      report_mismatch($sformatf("early writes lane 0 %0d lane 1 %0d, expected 0 and 1",
                                got_q[0].size(), got_q[1].size()));
    @(posedge clk_i);
    gnt_enable[0] = 1'b1;
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_unmasked();
    run_insn(3'd1, 16'd128, 1'b1, 5'd3, "unmasked");
  endtask

  task automatic test_tail();
    run_insn(3'd2, 16'd70, 1'b1, 5'd5, "tail");
  endtask

  task automatic test_masked();
    run_insn(3'd3, 16'd128, 1'b0, 5'd7, "masked");
  endtask

  task automatic test_multi_word();
    run_insn(3'd4, 16'd300, 1'b1, 5'd10, "multi-word");
  endtask

  task automatic test_back_pressure();
    @(posedge clk_i);
    gnt_enable = '0;
    send_request(3'd6, 16'd384, 1'b0, 5'd31);
    fork
      feed_operands(3'd6, 16'd384, 1'b0, 5'd31);
      hold_then_release_grants();
    join
    wait_done_and_check(3'd6, 3, "back-pressure");
  endtask

  initial begin
    seed              = 32'h97bb5ac1;
    gnt_enable        = '1;
    pe_req_valid_i    <= 1'b0;
    pe_req_id_i       <= '0;
    pe_req_vl_i       <= '0;
    pe_req_vm_i       <= 1'b0;
    pe_req_vd_i       <= '0;
    operand_a_i       <= '0;
    operand_b_i       <= '0;
    operand_m_i       <= '0;
    operand_a_valid_i <= '0;
    operand_b_valid_i <= '0;
    operand_m_valid_i <= '0;
    @(posedge rst_ni);
    @(negedge clk_i);
    // Idle state after reset
    check_flag(pe_req_ready_o, 1'b1, "sequencer ready after reset");
    check_lanes(operand_a_ready_o, '0, "a ready after reset");
    check_lanes(operand_b_ready_o, '0, "b ready after reset");
    check_lanes(operand_m_ready_o, '0, "m ready after reset");
    check_lanes(result_req_o, '0, "requests after reset");
    check_done(vinsn_done_o, '0, "after reset");
    test_unmasked();
    test_tail();
    test_masked();
    test_multi_word();
    test_back_pressure();
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- masku.f
design/masku_pkg.sv
design/masku_insn_ctrl.sv
design/masku_bit_merge.sv
design/masku_result_queue.sv
design/masku.sv
test/tb_clock.sv
test/tb_masku.sv

//--- build.sh
#!/usr/bin/env bash
# Build the masku testbench with Verilator and run it.
# The simulator exit status decides pass or fail.
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert -j 0 \
    --top-module tb_masku -f masku.f -o tb_masku; then
  echo "Verilator build failed"
  exit 1
fi

if [ ! -x ./obj_dir/tb_masku ]; then
  echo "Simulation binary missing"
  exit 1
fi

if ! ./obj_dir/tb_masku; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0
